//--- rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path word width
`define XPR_LEN 32

// register index width, 32 architectural registers
`define REG_ADDR_WIDTH 5

// addi x0, x0, 0
`define RV_NOP 32'h00000013

// first register of the duplicate half, x16 and up
`define QED_DUP_BASE 16

// commit counters wrap modulo 32
`define QED_CNT_WIDTH 5

`endif

//--- rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

   // one data word
   typedef logic [`XPR_LEN-1:0] word_t;

   // architectural register index
   typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

   // major opcodes, only the two integer ALU classes are handled
   typedef enum logic [6:0] {
      op_reg = 7'b0110011,
      op_imm = 7'b0010011
   } opcode_t;

   // alu operations
   // bit 3 marks the inverted or signed variants
   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sll  = 4'd1,
      alu_xor  = 4'd4,
      alu_srl  = 4'd5,
      alu_or   = 4'd6,
      alu_and  = 4'd7,
      alu_sub  = 4'd10,
      alu_sra  = 4'd11,
      alu_slt  = 4'd12,
      alu_sltu = 4'd14
   } alu_op_t;

endpackage

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module decode_stage import rv_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  word_t     inst,
   input  logic      inst_valid,
   output reg_addr_t rs1_addr,
   output reg_addr_t rs2_addr,
   output reg_addr_t rd_addr,
   output logic      wr_reg,
   output alu_op_t   alu_op,
   output word_t     imm,
   output logic      use_imm
);

   word_t   inst_q;
   opcode_t opcode;
   logic    supported;
   logic    is_shift;

   // decode register, a missing instruction becomes a bubble
   always_ff @(posedge clk) begin
      if (reset) begin
         inst_q <= `RV_NOP;
      end else if (inst_valid) begin
         inst_q <= inst;
      end else begin
         inst_q <= `RV_NOP;
      end
   end

   // register fields sit at fixed positions
   assign rs1_addr = inst_q[19:15];
   assign rs2_addr = inst_q[24:20];
   assign rd_addr  = inst_q[11:7];

   assign opcode    = opcode_t'(inst_q[6:0]);
   assign supported = (opcode == op_reg) || (opcode == op_imm);
   assign use_imm   = (opcode == op_imm);
   // slli / srli / srai
   assign is_shift  = (inst_q[13:12] == 2'b01);

   // writes to x0 are dropped here so later stages never see them
   assign wr_reg = supported && (inst_q[11:7] != '0);

   always_comb begin
      case (inst_q[14:12])
         // bit 30 selects sub, but only for register form
         3'd0: alu_op = (opcode == op_reg && inst_q[30]) ? alu_sub : alu_add;
         3'd1: alu_op = alu_sll;
         3'd2: alu_op = alu_slt;
         3'd3: alu_op = alu_sltu;
         3'd4: alu_op = alu_xor;
         // srai carries bit 30 as well
         3'd5: alu_op = inst_q[30] ? alu_sra : alu_srl;
         3'd6: alu_op = alu_or;
         default: alu_op = alu_and;
      endcase
   end

   // i-type immediate, shifts keep only shamt
   always_comb begin
      if (is_shift) begin
         imm = {{(`XPR_LEN-5){1'b0}}, inst_q[24:20]};
      end else begin
         imm = {{(`XPR_LEN-12){inst_q[31]}}, inst_q[31:20]};
      end
   end

   // no write request may target the zero register
   a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
      !(wr_reg && rd_addr == '0));

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile import rv_pkg::*; (
   input  logic      clk,
   input  reg_addr_t ra1,
   output word_t     rd1,
   input  reg_addr_t ra2,
   output word_t     rd2,
   input  logic      wen,
   input  reg_addr_t wa,
   input  word_t     wd
);

   // x0 has no storage
   word_t regs [1:31];

   always_ff @(posedge clk) begin
      if (wen && wa != '0) begin
         regs[wa] <= wd;
      end
   end

   // asynchronous reads, zero register reads as zero
   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

   // decode filters x0 writes before they reach writeback
   a_no_wen_x0: assert property (@(posedge clk) !(wen && wa == '0));

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import rv_pkg::*; (
   input  alu_op_t op,
   input  word_t   in1,
   input  word_t   in2,
   output word_t   out
);

   logic [4:0] shamt;

   // shifts only look at the low five bits
   assign shamt = in2[4:0];

   always_comb begin
      case (op)
         alu_add:  out = in1 + in2;
         alu_sub:  out = in1 - in2;
         alu_sll:  out = in1 << shamt;
         // compares yield 0 or 1
         alu_slt:  out = word_t'($signed(in1) < $signed(in2));
         alu_sltu: out = word_t'(in1 < in2);
         alu_xor:  out = in1 ^ in2;
         alu_srl:  out = in1 >> shamt;
         // arithmetic shift keeps the sign
         alu_sra:  out = word_t'($signed(in1) >>> shamt);
         alu_or:   out = in1 | in2;
         alu_and:  out = in1 & in2;
         default:  out = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exec_stage import rv_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  reg_addr_t rs1_addr,
   input  reg_addr_t rs2_addr,
   input  reg_addr_t rd_addr,
   input  logic      wr_reg,
   input  alu_op_t   alu_op,
   input  word_t     imm,
   input  logic      use_imm,
   output logic      wb_en,
   output reg_addr_t wb_addr,
   output word_t     wb_data
);

   word_t rs1_data;
   word_t rs2_data;
   word_t rs1_fwd;
   word_t rs2_fwd;
   word_t alu_in2;
   word_t alu_out;
   logic  bypass_rs1;
   logic  bypass_rs2;

   // writeback register feeds the write port directly
   regfile i_regfile (
      .clk (clk),
      .ra1 (rs1_addr),
      .rd1 (rs1_data),
      .ra2 (rs2_addr),
      .rd2 (rs2_data),
      .wen (wb_en),
      .wa  (wb_addr),
      .wd  (wb_data)
   );

   // result in writeback is not yet in the file
   // wb_en is never set for x0, so no extra zero check
   assign bypass_rs1 = wb_en && (wb_addr == rs1_addr);
   assign bypass_rs2 = wb_en && (wb_addr == rs2_addr);

   assign rs1_fwd = bypass_rs1 ? wb_data : rs1_data;
   assign rs2_fwd = bypass_rs2 ? wb_data : rs2_data;

   // op-imm takes the immediate as second operand
   assign alu_in2 = use_imm ? imm : rs2_fwd;

   alu i_alu (
      .op  (alu_op),
      .in1 (rs1_fwd),
      .in2 (alu_in2),
      .out (alu_out)
   );

   // write enable only
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_en <= 1'b0;
      end else begin
         wb_en <= wr_reg;
      end
   end

   // payload follows every cycle, qualified by wb_en
   always_ff @(posedge clk) begin
      wb_addr <= rd_addr;
      wb_data <= alu_out;
   end

   // nothing commits right out of reset
   a_wb_idle_after_reset: assert property (@(posedge clk) reset |=> !wb_en);

endmodule

`default_nettype wire

//--- qed_commit_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module qed_commit_checker import rv_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      wb_en,
   input  reg_addr_t wb_addr,
   output logic      qed_check_en
);

   // start delay, two edges after reset before counting
   typedef enum logic [1:0] {
      st_wait0,
      st_wait1,
      st_run
   } start_state_t;

   start_state_t                state_q;
   logic [`QED_CNT_WIDTH-1:0]   orig_cnt;
   logic [`QED_CNT_WIDTH-1:0]   dup_cnt;
   logic                        orig_commit;
   logic                        dup_commit;

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= st_wait0;
      end else begin
         case (state_q)
            st_wait0: state_q <= st_wait1;
            st_wait1: state_q <= st_run;
            default:  state_q <= st_run;
         endcase
      end
   end

   // x1..x15 are originals, x16..x31 duplicates
   // x0 never commits, excluded anyway
   assign orig_commit = wb_en && (wb_addr != '0)
                        && (wb_addr < `REG_ADDR_WIDTH'(`QED_DUP_BASE));
   assign dup_commit  = wb_en && (wb_addr >= `REG_ADDR_WIDTH'(`QED_DUP_BASE));

   // counters held clear until the delay ends, then wrap freely
   always_ff @(posedge clk) begin
      if (reset || state_q != st_run) begin
         orig_cnt <= '0;
         dup_cnt  <= '0;
      end else begin
         if (orig_commit) begin
            orig_cnt <= orig_cnt + `QED_CNT_WIDTH'(1);
         end
         if (dup_commit) begin
            dup_cnt <= dup_cnt + `QED_CNT_WIDTH'(1);
         end
      end
   end

   // balanced counts, check allowed
   assign qed_check_en = (orig_cnt == dup_cnt);

   // one commit per cycle, so only one side can move
   a_single_count_step: assert property (@(posedge clk) disable iff (reset)
      $stable(orig_cnt) || $stable(dup_cnt));

endmodule

`default_nettype wire

//--- rv_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_top import rv_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  word_t     inst,
   input  logic      inst_valid,
   output logic      wb_en,
   output reg_addr_t wb_addr,
   output word_t     wb_data,
   output logic      qed_check_en
);

   // decoded operation, decode to execute
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   reg_addr_t rd_addr;
   logic      wr_reg;
   alu_op_t   alu_op;
   word_t     imm;
   logic      use_imm;

   decode_stage i_decode_stage (
      .clk        (clk),
      .reset      (reset),
      .inst       (inst),
      .inst_valid (inst_valid),
      .rs1_addr   (rs1_addr),
      .rs2_addr   (rs2_addr),
      .rd_addr    (rd_addr),
      .wr_reg     (wr_reg),
      .alu_op     (alu_op),
      .imm        (imm),
      .use_imm    (use_imm)
   );

   exec_stage i_exec_stage (
      .clk      (clk),
      .reset    (reset),
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .rd_addr  (rd_addr),
      .wr_reg   (wr_reg),
      .alu_op   (alu_op),
      .imm      (imm),
      .use_imm  (use_imm),
      .wb_en    (wb_en),
      .wb_addr  (wb_addr),
      .wb_data  (wb_data)
   );

   // checker watches the same write port
   qed_commit_checker i_qed_commit_checker (
      .clk          (clk),
      .reset        (reset),
      .wb_en        (wb_en),
      .wb_addr      (wb_addr),
      .qed_check_en (qed_check_en)
   );

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module tb_rv_core;

   // roughly 1450 stimulus cycles, about twice that as the limit
   localparam int timeout_cycles = 3000;

   logic                       clk;
   logic                       reset;
   logic [`XPR_LEN-1:0]        inst;
   logic                       inst_valid;
   logic                       wb_en;
   logic [`REG_ADDR_WIDTH-1:0] wb_addr;
   logic [`XPR_LEN-1:0]        wb_data;
   logic                       qed_check_en;

   // reference register file, x0 stays zero
   logic [`XPR_LEN-1:0]        ref_regs [0:31];
   // expected writes, index 2 lines up with the writeback stage
   logic                       exp_en   [0:2];
   logic [`REG_ADDR_WIDTH-1:0] exp_addr [0:2];
   logic [`XPR_LEN-1:0]        exp_data [0:2];
   logic [`QED_CNT_WIDTH-1:0]  ref_orig_cnt;
   logic [`QED_CNT_WIDTH-1:0]  ref_dup_cnt;
   logic [31:0]                lfsr;
   logic [`REG_ADDR_WIDTH-1:0] prev_rd;
   int                         cycle_count;

   rv_core_top i_rv_core_top (
      .clk          (clk),
      .reset        (reset),
      .inst         (inst),
      .inst_valid   (inst_valid),
      .wb_en        (wb_en),
      .wb_addr      (wb_addr),
      .wb_data      (wb_data),
      .qed_check_en (qed_check_en)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // galois lfsr, one step for every bit handed out
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);
      end
      return v;
   endfunction

   // integer result by the isa rules
   function automatic logic [31:0] ref_alu(input logic [2:0] funct3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
      logic [4:0] sh;
      sh = b[4:0];
      case (funct3)
         3'd0: ref_alu = alt ? a - b : a + b;
         3'd1: ref_alu = a << sh;
         3'd2: ref_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: ref_alu = (a < b) ? 32'd1 : 32'd0;
         3'd4: ref_alu = a ^ b;
         3'd5: ref_alu = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
         3'd6: ref_alu = a | b;
         default: ref_alu = a & b;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "mismatch on %s", name);
   endtask

   // drive one instruction at the next edge, model it in order
   task automatic issue(input logic valid, input logic [31:0] instr);
      logic        is_reg;
      logic        writes;
      logic        alt;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] result;
      is_reg = (instr[6:0] == 7'b0110011);
      a      = ref_regs[instr[19:15]];
      if (is_reg) begin
         b   = ref_regs[instr[24:20]];
         alt = instr[30] && (instr[14:12] == 3'd0 || instr[14:12] == 3'd5);
      end else begin
         // sign-extended i-type, shamt sits in the low five bits
         b   = {{20{instr[31]}}, instr[31:20]};
         alt = instr[30] && (instr[14:12] == 3'd5);
      end
      writes = valid && (is_reg || instr[6:0] == 7'b0010011) && (instr[11:7] != 5'd0);
      result = ref_alu(instr[14:12], alt, a, b);
      @(posedge clk);
      inst        <= instr;
      inst_valid  <= valid;
      exp_en[0]   <= writes;
      exp_addr[0] <= instr[11:7];
      exp_data[0] <= result;
      if (writes) begin
         ref_regs[instr[11:7]] = result;
         prev_rd = instr[11:7];
      end
   endtask

   // bubbles while reset is high, released on the last one
   task automatic apply_reset();
      int i;
      for (i = 0; i < 10; i++) begin
         issue(1'b0, `RV_NOP);
         reset <= 1'b1;
      end
      issue(1'b0, `RV_NOP);
      reset <= 1'b0;
   endtask

   // dep ties a source to the last destination
   task automatic random_alu(input logic use_imm, input logic dep);
      logic [2:0]  funct3;
      logic        alt;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm12;
      funct3 = 3'(take_bits(3));
      alt    = 1'(take_bits(1));
      rd     = 5'(take_bits(5));
      rs1    = 5'(take_bits(5));
      rs2    = 5'(take_bits(5));
      if (dep) begin
         rs1 = prev_rd;
         if (take_bits(1) == 32'd1) begin
            rs2 = prev_rd;
         end
      end
      if (!use_imm) begin
         issue(1'b1, {1'b0, alt, 5'd0, rs2, rs1, funct3, rd, 7'b0110011});
      end else if (funct3 == 3'd1 || funct3 == 3'd5) begin
         // slli, srli, srai
         issue(1'b1, {1'b0, alt, 5'd0, rs2, rs1, funct3, rd, 7'b0010011});
      end else begin
         imm12 = 12'(take_bits(12));
         issue(1'b1, {imm12, rs1, funct3, rd, 7'b0010011});
      end
   endtask

   // bubbles, foreign opcodes and x0 targets among dependent ops
   task automatic random_junk();
      logic [31:0] word;
      logic [1:0]  kind;
      kind = 2'(take_bits(2));
      word = take_bits(32);
      case (kind)
         2'd0: issue(1'b0, word);
         2'd1: begin
            // lui / auipc instead of the alu classes
            if (word[6:0] == 7'b0110011 || word[6:0] == 7'b0010011) begin
               word[2] = ~word[2];
            end
            issue(1'b1, word);
         end
         2'd2: issue(1'b1, {word[31:12], 5'd0, 7'b0010011});
         default: random_alu(1'(take_bits(1)), 1'b1);
      endcase
   endtask

   // original to x1..x15, then the copy on x16..x31
   task automatic qed_pair(input int gap);
      logic [31:0] orig;
      logic [3:0]  rd;
      int          i;
      rd = 4'(take_bits(4));
      if (rd == 4'd0) begin
         rd = 4'd1;
      end
      orig = {1'b0, 1'(take_bits(1)), 5'd0, 1'b0, 4'(take_bits(4)), 1'b0, 4'(take_bits(4)),
              3'(take_bits(3)), 1'b0, rd, 7'b0110011};
      issue(1'b1, orig);
      // gap leaves the original unpaired for a while
      for (i = 0; i < gap; i++) begin
         issue(1'b0, `RV_NOP);
      end
      issue(1'b1, {orig[31:25], 1'b1, orig[23:20], 1'b1, orig[18:12], 1'b1, orig[10:0]});
   endtask

   // delay line and commit counts, checker start delay needs no model
   always @(posedge clk) begin
      exp_en[1]   <= exp_en[0];
      exp_addr[1] <= exp_addr[0];
      exp_data[1] <= exp_data[0];
      exp_en[2]   <= exp_en[1];
      exp_addr[2] <= exp_addr[1];
      exp_data[2] <= exp_data[1];
      if (reset) begin
         ref_orig_cnt <= '0;
         ref_dup_cnt  <= '0;
      end else if (exp_en[2] && exp_addr[2] < 5'(`QED_DUP_BASE)) begin
         ref_orig_cnt <= ref_orig_cnt + 1'b1;
      end else if (exp_en[2]) begin
         ref_dup_cnt <= ref_dup_cnt + 1'b1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout, stimulus still running after %0d cycles", timeout_cycles);
         $display("Finished with errors");
         $fatal(1, "timeout");
      end
   end

   a_reset_state: assert property (@(posedge clk) $fell(reset) |-> !wb_en && qed_check_en)
      else report_mismatch("wb_en,qed_check_en", 32'd1,
                           32'({$sampled(wb_en), $sampled(qed_check_en)}));
   a_wb_en: assert property (@(posedge clk) disable iff (reset) wb_en == exp_en[2])
      else report_mismatch("wb_en", 32'($sampled(exp_en[2])), 32'($sampled(wb_en)));
   a_wb_addr: assert property (@(posedge clk) disable iff (reset)
      exp_en[2] |-> wb_addr == exp_addr[2])
      else report_mismatch("wb_addr", 32'($sampled(exp_addr[2])), 32'($sampled(wb_addr)));
   a_wb_data: assert property (@(posedge clk) disable iff (reset)
      exp_en[2] |-> wb_data == exp_data[2])
      else report_mismatch("wb_data", $sampled(exp_data[2]), $sampled(wb_data));
   a_qed_check_en: assert property (@(posedge clk) disable iff (reset)
      qed_check_en == (ref_orig_cnt == ref_dup_cnt))
      else report_mismatch("qed_check_en", 32'($sampled(ref_orig_cnt == ref_dup_cnt)),
                           32'($sampled(qed_check_en)));

   initial begin
      int i;
      reset        = 1'b1;
      inst         = `RV_NOP;
      inst_valid   = 1'b0;
      lfsr         = 32'hbe4445d0;
      cycle_count  = 0;
      prev_rd      = '0;
      ref_orig_cnt = '0;
      ref_dup_cnt  = '0;
      for (i = 0; i < 32; i++) begin
         ref_regs[i] = '0;
      end
      for (i = 0; i < 3; i++) begin
         exp_en[i]   = 1'b0;
         exp_addr[i] = '0;
         exp_data[i] = '0;
      end
      apply_reset();
      // register file has no reset, seed every entry first
      for (i = 1; i < 32; i++) begin
         issue(1'b1, {12'(take_bits(12)), 5'd0, 3'd0, 5'(i), 7'b0010011});
      end
      for (i = 0; i < 300; i++) begin
         random_alu(1'b0, 1'b0);
      end
      for (i = 0; i < 300; i++) begin
         random_alu(1'b1, 1'b0);
      end
      for (i = 0; i < 200; i++) begin
         random_alu(1'(take_bits(1)), 1'b1);
      end
      for (i = 0; i < 200; i++) begin
         random_junk();
      end
      // drain, then clear the commit counters
      for (i = 0; i < 4; i++) begin
         issue(1'b0, `RV_NOP);
      end
      apply_reset();
      for (i = 0; i < 100; i++) begin
         qed_pair(int'(take_bits(2)));
      end
      // last duplicate shows on qed_check_en four edges after issue
      for (i = 0; i < 5; i++) begin
         issue(1'b0, `RV_NOP);
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
rv_pkg.sv
decode_stage.sv
regfile.sv
alu.sv
exec_stage.sv
qed_commit_checker.sv
rv_core_top.sv
tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_rv_core -f files.f -o sim_tb_rv_core
# the log decides pass or fail, so a non-zero exit must not stop the script here
./obj_dir/sim_tb_rv_core > sim.log 2>&1 || true
cat sim.log
if grep -q "^Finished with no errors$" sim.log; then
   exit 0
fi
exit 1
